//--- rtl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // compares return 0/1 in bit 0
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } res_src_t;

    // same coding as funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    localparam word_t INSTR_STEP = 32'd4;

endpackage

//--- rtl/rv_control.sv
`timescale 1ns/1ps

module rv_control
#(
    parameter rv_pkg::word_t RESET_ADDR = 32'h0000_0000
)
(
    input  logic          i_clk,
    input  logic          i_reset_n,
    input  logic          i_mem_ack,
    input  rv_pkg::word_t i_mem_rdata,
    input  logic          i_is_load,
    input  logic          i_is_store,
    input  logic          i_is_branch,
    input  logic          i_is_jal,
    input  logic          i_is_jalr,
    input  logic          i_reg_write,
    input  rv_pkg::word_t i_alu_result,
    input  logic          i_branch_taken,
    input  rv_pkg::word_t i_imm,
    output logic          o_mem_req,
    output logic          o_mem_we,
    output rv_pkg::word_t o_mem_addr,
    output rv_pkg::word_t o_instr,
    output rv_pkg::word_t o_pc,
    output rv_pkg::word_t o_ex_result,
    output rv_pkg::word_t o_load_data,
    output logic          o_reg_we
);
    import rv_pkg::*;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEM,
        ST_WRITEBACK
    } state_t;

    state_t state;
    logic   req_q;
    logic   we_q;
    logic   ack_seen;
    logic   taken_q;
    logic   bus_phase;
    logic   bus_capture;
    logic   bus_done;
    word_t  pc;
    word_t  instr;
    word_t  ex_result;
    word_t  load_data;

    assign bus_phase   = (state == ST_FETCH) || (state == ST_MEM);
    assign bus_capture = req_q && i_mem_ack;
    // handshake over once ack has dropped again
    assign bus_done    = ack_seen && !i_mem_ack;

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            state    <= ST_FETCH;
            pc       <= RESET_ADDR;
            req_q    <= 1'b0;
            we_q     <= 1'b0;
            ack_seen <= 1'b0;
        end
        else
        begin
            if (bus_phase)
            begin
                if (!req_q && !ack_seen && !i_mem_ack)
                begin
                    req_q <= 1'b1;
                    we_q  <= (state == ST_MEM) && i_is_store;
                end
                else if (bus_capture)
                begin
                    req_q    <= 1'b0;
                    we_q     <= 1'b0;
                    ack_seen <= 1'b1;
                end
                else if (bus_done)
                begin
                    ack_seen <= 1'b0;
                end
            end

            case (state)
                ST_FETCH:
                    if (bus_done)
                        state <= ST_DECODE;
                ST_DECODE:
                    state <= ST_EXECUTE;
                ST_EXECUTE:
                    state <= (i_is_load || i_is_store) ? ST_MEM : ST_WRITEBACK;
                ST_MEM:
                    if (bus_done)
                        state <= ST_WRITEBACK;
                ST_WRITEBACK:
                begin
                    state <= ST_FETCH;
                    if (i_is_jal || i_is_jalr)
                        pc <= {ex_result[31:1], 1'b0};
                    else if (i_is_branch && taken_q)
                        pc <= pc + i_imm;
                    else
                        pc <= pc + INSTR_STEP;
                end
                default:
                    state <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (state == ST_FETCH && bus_capture)
            instr <= i_mem_rdata;
        if (state == ST_MEM && bus_capture)
            load_data <= i_mem_rdata;
        if (state == ST_EXECUTE)
        begin
            ex_result <= i_alu_result;
            taken_q   <= i_branch_taken;
        end
    end

    assign o_mem_req   = req_q;
    assign o_mem_we    = we_q;
    assign o_mem_addr  = (state == ST_MEM) ? ex_result : pc;
    assign o_instr     = instr;
    assign o_pc        = pc;
    assign o_ex_result = ex_result;
    assign o_load_data = load_data;
    assign o_reg_we    = (state == ST_WRITEBACK) && i_reg_write;

endmodule

//--- rtl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder
(
    input  rv_pkg::word_t     i_instr,
    output rv_pkg::reg_idx_t  o_rs1,
    output rv_pkg::reg_idx_t  o_rs2,
    output rv_pkg::reg_idx_t  o_rd,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::alu_op_t   o_alu_op,
    output logic              o_op1_pc,
    output logic              o_op2_imm,
    output rv_pkg::res_src_t  o_res_src,
    output rv_pkg::mem_size_t o_size,
    output logic              o_unsigned,
    output logic              o_is_load,
    output logic              o_is_store,
    output logic              o_is_branch,
    output logic              o_is_jal,
    output logic              o_is_jalr,
    output logic              o_reg_write
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       is_auipc;

    // shared by register and immediate forms
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic sub_ok,
                                         input logic alt_bit);
        alu_op_t op;
        case (f3)
            3'b000:  op = (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign alt    = (i_instr[31:25] == FUNCT7_ALT);

    assign is_op       = (opcode == OPC_OP);
    assign is_op_imm   = (opcode == OPC_OP_IMM);
    assign is_lui      = (opcode == OPC_LUI);
    assign is_auipc    = (opcode == OPC_AUIPC);
    assign o_is_load   = (opcode == OPC_LOAD);
    assign o_is_store  = (opcode == OPC_STORE);
    assign o_is_branch = (opcode == OPC_BRANCH);
    assign o_is_jal    = (opcode == OPC_JAL);
    assign o_is_jalr   = (opcode == OPC_JALR);
    assign o_reg_write = o_is_load || is_op || is_op_imm || is_lui || is_auipc
                         || o_is_jal || o_is_jalr;

    // lui becomes x0 + imm
    assign o_rs1 = is_lui ? 5'd0 : i_instr[19:15];
    assign o_rs2 = i_instr[24:20];
    assign o_rd  = i_instr[11:7];

    always_comb
    begin
        case (opcode)
            OPC_STORE:
                o_imm = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
            OPC_BRANCH:
                o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                o_imm = {i_instr[31:12], 12'd0};
            OPC_JAL:
                o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
            default:
                o_imm = {{21{i_instr[31]}}, i_instr[30:20]};
        endcase
    end

    always_comb
    begin
        o_alu_op = ALU_ADD;
        if (is_op)
            o_alu_op = arith_op(funct3, 1'b1, alt);
        else if (is_op_imm)
            o_alu_op = arith_op(funct3, 1'b0, alt);
        else if (o_is_branch)
        begin
            case (funct3)
                3'b001:  o_alu_op = ALU_NE;
                3'b100:  o_alu_op = ALU_LT;
                3'b101:  o_alu_op = ALU_GE;
                3'b110:  o_alu_op = ALU_LTU;
                3'b111:  o_alu_op = ALU_GEU;
                default: o_alu_op = ALU_EQ;
            endcase
        end
    end

    assign o_op1_pc  = is_auipc || o_is_jal;
    assign o_op2_imm = !(is_op || o_is_branch);

    assign o_res_src  = o_is_load ? RES_MEM :
                        (o_is_jal || o_is_jalr) ? RES_PC4 : RES_ALU;
    assign o_size     = mem_size_t'(funct3[1:0]);
    assign o_unsigned = funct3[2];

endmodule

//--- rtl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile
(
    input  logic             i_clk,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_we,
    input  rv_pkg::word_t    i_wdata,
    output rv_pkg::word_t    o_rdata1,
    output rv_pkg::word_t    o_rdata2
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge i_clk)
    begin
        if (i_we && i_rd != 5'd0)
            regs[i_rd] <= i_wdata;
    end

    assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

//--- rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu
(
    input  rv_pkg::alu_op_t i_alu_op,
    input  logic            i_op1_pc,
    input  logic            i_op2_imm,
    input  rv_pkg::word_t   i_pc,
    input  rv_pkg::word_t   i_rdata1,
    input  rv_pkg::word_t   i_rdata2,
    input  rv_pkg::word_t   i_imm,
    output rv_pkg::word_t   o_result,
    output logic            o_branch_taken
);
    import rv_pkg::*;

    word_t       op1;
    word_t       op2;
    logic        subtract;
    logic [32:0] sum;
    logic        overflow;
    logic        eq;
    logic        lts;
    logic        ltu;
    logic [4:0]  shamt;
    logic        cmp;

    assign op1   = i_op1_pc ? i_pc : i_rdata1;
    assign op2   = i_op2_imm ? i_imm : i_rdata2;
    assign shamt = op2[4:0];

    // one adder, inverted operand for sub and compares
    assign subtract = (i_alu_op != ALU_ADD);
    assign sum      = {1'b0, op1} + {1'b0, subtract ? ~op2 : op2} + {32'd0, subtract};
    assign overflow = (op1[31] ^ op2[31]) & (op1[31] ^ sum[31]);
    assign eq       = (sum[31:0] == 32'd0);
    assign lts      = sum[31] ^ overflow;
    assign ltu      = !sum[32];

    always_comb
    begin
        cmp = 1'b0;
        case (i_alu_op)
            ALU_SLT, ALU_LT:   cmp = lts;
            ALU_GE:            cmp = !lts;
            ALU_SLTU, ALU_LTU: cmp = ltu;
            ALU_GEU:           cmp = !ltu;
            ALU_EQ:            cmp = eq;
            ALU_NE:            cmp = !eq;
            default:           cmp = 1'b0;
        endcase
    end

    always_comb
    begin
        case (i_alu_op)
            ALU_ADD, ALU_SUB: o_result = sum[31:0];
            ALU_SLL:          o_result = op1 << shamt;
            ALU_SRL:          o_result = op1 >> shamt;
            ALU_SRA:          o_result = $signed(op1) >>> shamt;
            ALU_XOR:          o_result = op1 ^ op2;
            ALU_OR:           o_result = op1 | op2;
            ALU_AND:          o_result = op1 & op2;
            default:          o_result = {31'd0, cmp};
        endcase
    end

    assign o_branch_taken = cmp;

endmodule

//--- rtl/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu
(
    input  rv_pkg::mem_size_t i_size,
    input  logic              i_unsigned,
    input  rv_pkg::res_src_t  i_res_src,
    input  rv_pkg::word_t     i_addr,
    input  rv_pkg::word_t     i_store_data,
    input  rv_pkg::word_t     i_load_data,
    input  rv_pkg::word_t     i_pc,
    output rv_pkg::word_t     o_wdata,
    output logic [3:0]        o_sel,
    output rv_pkg::word_t     o_wb_data
);
    import rv_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       ld_value;

    // store lanes
    always_comb
    begin
        case (i_size)
            SIZE_BYTE:
            begin
                o_wdata = {4{i_store_data[7:0]}};
                o_sel   = 4'b0001 << i_addr[1:0];
            end
            SIZE_HALF:
            begin
                o_wdata = {2{i_store_data[15:0]}};
                o_sel   = i_addr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                o_wdata = i_store_data;
                o_sel   = 4'b1111;
            end
        endcase
    end

    assign ld_byte = i_load_data[{i_addr[1:0], 3'b000} +: 8];
    assign ld_half = i_addr[1] ? i_load_data[31:16] : i_load_data[15:0];

    always_comb
    begin
        case (i_size)
            SIZE_BYTE: ld_value = {{24{ld_byte[7] & !i_unsigned}}, ld_byte};
            SIZE_HALF: ld_value = {{16{ld_half[15] & !i_unsigned}}, ld_half};
            default:   ld_value = i_load_data;
        endcase
    end

    always_comb
    begin
        case (i_res_src)
            RES_MEM: o_wb_data = ld_value;
            RES_PC4: o_wb_data = i_pc + INSTR_STEP;
            default: o_wb_data = i_addr;
        endcase
    end

endmodule

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core
#(
    parameter rv_pkg::word_t RESET_ADDR = 32'h0000_0000
)
(
    input  logic          i_clk,
    input  logic          i_reset_n,
    output logic          o_mem_req,
    output logic          o_mem_we,
    input  logic          i_mem_ack,
    output rv_pkg::word_t o_mem_addr,
    output rv_pkg::word_t o_mem_wdata,
    output logic [3:0]    o_mem_sel,
    input  rv_pkg::word_t i_mem_rdata
);
    import rv_pkg::*;

    word_t     instr;
    word_t     pc;
    word_t     ex_result;
    word_t     load_data;
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_result;
    word_t     wb_data;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    alu_op_t   alu_op;
    res_src_t  res_src;
    mem_size_t size;
    logic      op1_pc;
    logic      op2_imm;
    logic      is_unsigned;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      reg_write;
    logic      reg_we;
    logic      branch_taken;

    rv_control #(
        .RESET_ADDR (RESET_ADDR)
    ) u_control (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_mem_ack      (i_mem_ack),
        .i_mem_rdata    (i_mem_rdata),
        .i_is_load      (is_load),
        .i_is_store     (is_store),
        .i_is_branch    (is_branch),
        .i_is_jal       (is_jal),
        .i_is_jalr      (is_jalr),
        .i_reg_write    (reg_write),
        .i_alu_result   (alu_result),
        .i_branch_taken (branch_taken),
        .i_imm          (imm),
        .o_mem_req      (o_mem_req),
        .o_mem_we       (o_mem_we),
        .o_mem_addr     (o_mem_addr),
        .o_instr        (instr),
        .o_pc           (pc),
        .o_ex_result    (ex_result),
        .o_load_data    (load_data),
        .o_reg_we       (reg_we)
    );

    rv_decoder u_decoder (
        .i_instr     (instr),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_rd        (rd),
        .o_imm       (imm),
        .o_alu_op    (alu_op),
        .o_op1_pc    (op1_pc),
        .o_op2_imm   (op2_imm),
        .o_res_src   (res_src),
        .o_size      (size),
        .o_unsigned  (is_unsigned),
        .o_is_load   (is_load),
        .o_is_store  (is_store),
        .o_is_branch (is_branch),
        .o_is_jal    (is_jal),
        .o_is_jalr   (is_jalr),
        .o_reg_write (reg_write)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_rd     (rd),
        .i_we     (reg_we),
        .i_wdata  (wb_data),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2)
    );

    rv_alu u_alu (
        .i_alu_op       (alu_op),
        .i_op1_pc       (op1_pc),
        .i_op2_imm      (op2_imm),
        .i_pc           (pc),
        .i_rdata1       (rdata1),
        .i_rdata2       (rdata2),
        .i_imm          (imm),
        .o_result       (alu_result),
        .o_branch_taken (branch_taken)
    );

    rv_lsu u_lsu (
        .i_size       (size),
        .i_unsigned   (is_unsigned),
        .i_res_src    (res_src),
        .i_addr       (ex_result),
        .i_store_data (rdata2),
        .i_load_data  (load_data),
        .i_pc         (pc),
        .o_wdata      (o_mem_wdata),
        .o_sel        (o_mem_sel),
        .o_wb_data    (wb_data)
    );

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
    import rv_pkg::*;

    localparam logic [31:0] DONE_ADDR = 32'h0000_07fc;
    localparam int          RES_BASE  = 32'h400;
    localparam int          RUN_LIMIT = 20000;

    logic        clk;
    logic        reset_n;
    logic        mem_req;
    logic        mem_we;
    logic        mem_ack;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_sel;
    logic [31:0] mem_rdata;

    logic [31:0] mem [0:1023];
    logic [31:0] exp_q [$];
    int          wp;
    int          errors;
    logic        done;
    logic        rand_delay;
    int          delay;
    int          wait_cnt;
    logic [31:0] lfsr;
    logic        prev_req;
    logic        prev_ack;
    logic        got_ack;

    rv_core #(
        .RESET_ADDR (32'h0000_0000)
    ) i_rv_core (
        .i_clk       (clk),
        .i_reset_n   (reset_n),
        .o_mem_req   (mem_req),
        .o_mem_we    (mem_we),
        .i_mem_ack   (mem_ack),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_sel   (mem_sel),
        .i_mem_rdata (mem_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois lfsr stepped once per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            v = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // memory model answering req after delay cycles
    always @(posedge clk)
    begin
        #1;
        if (!reset_n)
        begin
            mem_ack  = 1'b0;
            wait_cnt = 0;
        end
        else if (mem_ack)
        begin
            if (!mem_req)
                mem_ack = 1'b0;
        end
        else if (mem_req)
        begin
            if (wait_cnt >= delay)
            begin
                mem_rdata = mem[mem_addr[11:2]];
                if (mem_we)
                begin
                    for (int l = 0; l < 4; l++)
                        if (mem_sel[l])
                            mem[mem_addr[11:2]][l*8 +: 8] = mem_wdata[l*8 +: 8];
                    if (mem_addr == DONE_ADDR)
                        done = 1'b1;
                end
                mem_ack  = 1'b1;
                wait_cnt = 0;
                delay    = rand_delay ? rand_bits(2) : 0;
            end
            else
                wait_cnt++;
        end
    end

    // handshake protocol monitor
    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            prev_req = 1'b0;
            prev_ack = 1'b0;
            got_ack  = 1'b0;
        end
        else
        begin
            // a rising req needs ack low in the cycle before
            assert (prev_req || !mem_req || !prev_ack)
            else
            begin
                errors++;
                $display("new req raised while ack was still high");
            end
            if (!prev_req && mem_req)
                got_ack = 1'b0;
            if (mem_req && mem_ack)
                got_ack = 1'b1;
            assert (!(prev_req && !mem_req && !got_ack))
            else
            begin
                errors++;
                $display("req dropped before ack was seen");
            end
            prev_req = mem_req;
            prev_ack = mem_ack;
        end
    end

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input int rs1,
                                          input logic [2:0] f3, input int rd,
                                          input logic [6:0] op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        // rd x3, rs1 x1, rs2 x2
        return {f7, 5'd2, 5'd1, f3, 5'd3, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input int rs2);
        return {imm[11:5], 5'(rs2), 5'd0, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[wp] = w;
        wp++;
    endtask

    task automatic load_imm(input int rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12;
        emit({upper[19:0], 5'(rd), OPC_LUI});
        emit(enc_i(v[11:0], rd, 3'b000, rd, OPC_OP_IMM));
    endtask

    function automatic logic [11:0] slot_off();
        return 12'(RES_BASE + 4 * exp_q.size());
    endfunction

    task automatic store_result(input int r, input logic [31:0] e);
        emit(enc_s(slot_off(), r));
        exp_q.push_back(e);
    endtask

    task automatic check_word(input string name, input logic [31:0] e, input logic [31:0] a);
        assert (e === a)
        else
        begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, e, a);
        end
    endtask

    // hold reset and refill memory for a new program at 0
    task automatic begin_load();
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        for (int i = 0; i < 1024; i++)
            mem[i] = (i * 32'h9e37_79b9) ^ 32'h2468_ace0;
        wp = 0;
        exp_q.delete();
        done = 1'b0;
    endtask

    task automatic run_program(input string name);
        int n;
        emit(enc_s(DONE_ADDR[11:0], 0));
        repeat (3)
        begin
            @(posedge clk);
            #1;
            assert (!mem_req)
            else
            begin
                errors++;
                $display("%s: req high during reset", name);
            end
        end
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        n = 0;
        while (!mem_req && n < 100)
        begin
            @(negedge clk);
            n++;
        end
        assert (mem_req)
        else
        begin
            errors++;
            $display("%s: no fetch request after reset", name);
        end
        check_word({name, " first fetch addr"}, 32'h0, mem_addr);
        check_word({name, " first fetch we"}, 32'h0, {31'd0, mem_we});
        n = 0;
        while (!done && n < RUN_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        assert (done)
        else
        begin
            errors++;
            $display("%s: timeout, program never reached the done store", name);
        end
        for (int k = 0; k < exp_q.size(); k++)
            check_word(name, exp_q[k], mem[RES_BASE / 4 + k]);
    endtask

    task automatic test_reset();
        begin_load();
        run_program("reset");
    endtask

    task automatic build_arith();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        a  = 32'h8000_0001;
        b  = 32'hffff_fff3;
        sh = b[4:0];
        load_imm(1, a);
        load_imm(2, b);
        emit(enc_r(7'h00, 3'b000));
        store_result(3, a + b);
        emit(enc_r(7'h20, 3'b000));
        store_result(3, a - b);
        emit(enc_r(7'h00, 3'b001));
        store_result(3, a << sh);
        emit(enc_r(7'h00, 3'b010));
        store_result(3, {31'd0, $signed(a) < $signed(b)});
        emit(enc_r(7'h00, 3'b011));
        store_result(3, {31'd0, a < b});
        emit(enc_r(7'h00, 3'b100));
        store_result(3, a ^ b);
        emit(enc_r(7'h00, 3'b101));
        store_result(3, a >> sh);
        emit(enc_r(7'h20, 3'b101));
        store_result(3, $signed(a) >>> sh);
        emit(enc_r(7'h00, 3'b110));
        store_result(3, a | b);
        emit(enc_r(7'h00, 3'b111));
        store_result(3, a & b);
        // slt x3, x2, x1
        emit({7'h00, 5'd1, 5'd2, 3'b010, 5'd3, OPC_OP});
        store_result(3, {31'd0, $signed(b) < $signed(a)});
        // sltu x3, x0, x1 differs from the signed result
        emit({7'h00, 5'd1, 5'd0, 3'b011, 5'd3, OPC_OP});
        store_result(3, {31'd0, 32'd0 < a});
        emit(enc_i(12'hffb, 1, 3'b000, 3, OPC_OP_IMM));
        store_result(3, a - 5);
        emit(enc_i(12'h0f0, 2, 3'b111, 3, OPC_OP_IMM));
        store_result(3, b & 32'hf0);
        emit(enc_i(12'hf00, 1, 3'b110, 3, OPC_OP_IMM));
        store_result(3, a | 32'hffff_ff00);
        emit(enc_i(12'hfff, 1, 3'b100, 3, OPC_OP_IMM));
        store_result(3, ~a);
        emit(enc_i(12'h007, 1, 3'b001, 3, OPC_OP_IMM));
        store_result(3, a << 7);
        emit(enc_i(12'h007, 1, 3'b101, 3, OPC_OP_IMM));
        store_result(3, a >> 7);
        emit(enc_i(12'h407, 1, 3'b101, 3, OPC_OP_IMM));
        store_result(3, $signed(a) >>> 7);
        emit(enc_i(12'hfff, 1, 3'b010, 3, OPC_OP_IMM));
        store_result(3, 32'd1);
        emit(enc_i(12'hfff, 1, 3'b011, 3, OPC_OP_IMM));
        store_result(3, 32'd1);
        emit(enc_i(12'h005, 2, 3'b011, 3, OPC_OP_IMM));
        store_result(3, {31'd0, b < 32'd5});
        // x0 stays zero
        emit(enc_i(12'h005, 1, 3'b000, 0, OPC_OP_IMM));
        store_result(0, 32'd0);
    endtask

    task automatic test_arith();
        begin_load();
        build_arith();
        run_program("arith");
    endtask

    task automatic test_upper();
        logic [31:0] p;
        begin_load();
        emit({20'habcde, 5'd5, OPC_LUI});
        store_result(5, 32'habcd_e000);
        p = wp * 4;
        emit({20'h12345, 5'd6, OPC_AUIPC});
        store_result(6, 32'h1234_5000 + p);
        run_program("upper");
    endtask

    task automatic test_control();
        logic [31:0] pa [3];
        logic [31:0] pb [3];
        logic [2:0]  f3s [6];
        logic [31:0] p;
        begin_load();
        pa  = '{32'd3, 32'hffff_fffb, 32'd3};
        pb  = '{32'd3, 32'd3, 32'hffff_fffb};
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int i = 0; i < 3; i++)
        begin
            load_imm(1, pa[i]);
            load_imm(2, pb[i]);
            foreach (f3s[j])
            begin
                emit(enc_i(12'h011, 0, 3'b000, 3, OPC_OP_IMM));
                emit(enc_b(13'd8, f3s[j]));
                // only on the fall-through path
                emit(enc_i(12'h022, 0, 3'b000, 3, OPC_OP_IMM));
                store_result(3, branch_rule(f3s[j], pa[i], pb[i]) ? 32'h11 : 32'h22);
            end
        end
        emit(enc_i(12'h044, 0, 3'b000, 8, OPC_OP_IMM));
        p = wp * 4;
        emit(enc_j(21'd8, 7));
        emit(enc_i(12'h033, 0, 3'b000, 8, OPC_OP_IMM));
        store_result(7, p + 4);
        store_result(8, 32'h44);
        p = wp * 4;
        emit({20'd0, 5'd9, OPC_AUIPC});
        emit(enc_i(12'd12, 9, 3'b000, 10, OPC_JALR));
        emit(enc_i(12'h055, 0, 3'b000, 8, OPC_OP_IMM));
        store_result(10, p + 8);
        store_result(8, 32'h44);
        run_program("control");
    endtask

    task automatic test_subword();
        logic [31:0] w;
        logic [11:0] base;
        logic [7:0]  bv;
        logic [15:0] hv;
        begin_load();
        w = 32'hf1e2_d3c4;
        load_imm(1, w);
        load_imm(2, 32'h1234_a5b6);
        for (int o = 0; o < 4; o++)
        begin
            emit(enc_s(slot_off(), 1));
            emit({7'(slot_off() >> 5), 5'd2, 5'd0, 3'b000, 5'(slot_off() + o), OPC_STORE});
            exp_q.push_back((w & ~(32'hff << (8 * o))) | (32'hb6 << (8 * o)));
        end
        for (int o = 0; o < 4; o += 2)
        begin
            emit(enc_s(slot_off(), 1));
            emit({7'(slot_off() >> 5), 5'd2, 5'd0, 3'b001, 5'(slot_off() + o), OPC_STORE});
            exp_q.push_back((w & ~(32'hffff << (8 * o))) | (32'ha5b6 << (8 * o)));
        end
        base = slot_off();
        store_result(1, w);
        for (int o = 0; o < 4; o++)
        begin
            bv = w[8 * o +: 8];
            emit(enc_i(base + 12'(o), 0, 3'b000, 3, OPC_LOAD));
            store_result(3, {{24{bv[7]}}, bv});
            emit(enc_i(base + 12'(o), 0, 3'b100, 3, OPC_LOAD));
            store_result(3, {24'd0, bv});
        end
        for (int o = 0; o < 4; o += 2)
        begin
            hv = w[8 * o +: 16];
            emit(enc_i(base + 12'(o), 0, 3'b001, 3, OPC_LOAD));
            store_result(3, {{16{hv[15]}}, hv});
            emit(enc_i(base + 12'(o), 0, 3'b101, 3, OPC_LOAD));
            store_result(3, {16'd0, hv});
        end
        run_program("subword");
    endtask

    task automatic test_backpressure();
        rand_delay = 1'b1;
        begin_load();
        build_arith();
        run_program("backpressure");
        rand_delay = 1'b0;
    endtask

    initial
    begin
        reset_n    = 1'b0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        errors     = 0;
        done       = 1'b0;
        rand_delay = 1'b0;
        delay      = 0;
        wait_cnt   = 0;
        lfsr       = 32'h9f94_b5a9;
        prev_req   = 1'b0;
        prev_ack   = 1'b0;
        got_ack    = 1'b0;
        test_reset();
        test_arith();
        test_upper();
        test_control();
        test_subword();
        test_backpressure();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- rv_core.f
rtl/rv_pkg.sv
rtl/rv_control.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_lsu.sv
rtl/rv_core.sv
verif/tb_rv_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_rv_core
FILELIST = rv_core.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
